//--- stream_settings.svh
// compile-time values; WORD_BYTES >= 1, FIFO_DEPTH >= 2, LEN_W must cover the longest frame
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// =========================================================================
// stream geometry
// =========================================================================

// bits per byte
`define BYTE_W 8

// bytes packed into one word, byte 0 in the low lane
`define WORD_BYTES 2

// =========================================================================
// buffering and frame bookkeeping
// =========================================================================

// FIFO entries, also sets the level width
`define FIFO_DEPTH 16

// frame length counter width, in words
`define LEN_W 12

`endif

//--- stream_pkg.sv
// level_t is sized for FIFO_DEPTH entries; a FIFO deeper than that overflows the level
`include "stream_settings.svh"

package stream_pkg;

    // =====================================================================
    // data widths
    // =====================================================================

    typedef logic [`BYTE_W-1:0]             byte_t;  // one input byte
    typedef logic [`BYTE_W*`WORD_BYTES-1:0] word_t;  // packed word, little-endian

    // =====================================================================
    // one FIFO entry, tlast / tuser / tdata order
    // =====================================================================

    typedef struct packed {
        logic  last;    // final word of the frame
        logic  user;    // error seen in this word
        word_t data;    // payload, pad lanes zero
    } beat_t;

    // =====================================================================
    // FIFO occupancy
    // =====================================================================

    // counts 0 up to and including the depth
    typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] level_t;

endpackage

//--- frame_pkg.sv
// needs stream_pkg compiled first; len_t wraps silently after 2**LEN_W words
`include "stream_settings.svh"

package frame_pkg;

    typedef logic [`LEN_W-1:0] len_t;  // frame length in words

    // one frame report from the sink
    typedef struct packed {
        len_t              len;    // words incl. padded last word
        stream_pkg::word_t sum;    // word sum mod 2**16
        logic              error;  // any byte flagged
    } frame_result_t;

    // packer: filling a word, or holding a finished beat
    typedef enum logic {
        pack_fill,
        pack_hold
    } pack_state_t;

    // sink: between frames, or partway through one
    typedef enum logic {
        sink_idle,
        sink_in_frame
    } sink_state_t;

endpackage

//--- byte_packer.sv
// single beat register with no skid buffer; a short last word is zero padded, no byte enables
`timescale 1ns/1ps
`include "stream_settings.svh"

module byte_packer
    import stream_pkg::*;
    import frame_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t in_byte,      // byte stream in
    input  logic  in_last,
    input  logic  in_error,
    input  logic  in_valid,
    output logic  in_ready,
    output beat_t out_beat,     // beat stream out
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int IDX_W = (`WORD_BYTES > 1) ? $clog2(`WORD_BYTES) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`WORD_BYTES - 1);

    pack_state_t      state;
    logic [IDX_W-1:0] idx;        // next lane to fill
    word_t            word_reg;   // word under construction, then the held beat
    logic             err_reg;    // OR of error flags in this word
    logic             last_reg;   // word closes the frame

    logic             drain;      // held beat leaves on this edge
    logic             take;       // byte accepted on this edge
    logic [IDX_W-1:0] base_idx;
    word_t            base_word;
    logic             base_err;
    word_t            word_next;
    logic             word_done;

    // =====================================================================
    // lane insert and handshake
    // =====================================================================

    always_comb begin
        drain    = (state == pack_hold) && out_ready;
        in_ready = (state == pack_fill) || drain;   // empty, or emptying now
        take     = in_valid && in_ready;
        // byte taken during a drain opens a fresh word
        base_idx  = (state == pack_hold) ? '0 : idx;
        base_word = (state == pack_hold) ? '0 : word_reg;
        base_err  = (state == pack_hold) ? 1'b0 : err_reg;
        word_next = base_word;
        word_next[base_idx*`BYTE_W +: `BYTE_W] = in_byte;  // byte 0 in low lane
        word_done = (base_idx == LAST_IDX) || in_last;     // full or frame end
    end

    // =====================================================================
    // state and word register
    // =====================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= pack_fill;
            idx      <= '0;
            word_reg <= '0;
            err_reg  <= 1'b0;
            last_reg <= 1'b0;
        end else if (take) begin
            word_reg <= word_next;
            err_reg  <= base_err | in_error;
            last_reg <= in_last;
            if (word_done) begin
                state <= pack_hold;              // beat visible next cycle
                idx   <= '0;
            end else begin
                state <= pack_fill;
                idx   <= base_idx + 1'b1;
            end
        end else if (drain) begin
            state    <= pack_fill;               // back to empty word
            idx      <= '0;
            word_reg <= '0;                      // pad lanes read zero
            err_reg  <= 1'b0;
            last_reg <= 1'b0;
        end
    end

    assign out_beat  = '{last: last_reg, user: err_reg, data: word_reg};
    assign out_valid = (state == pack_hold);

endmodule

//--- axis_srl_fifo.sv
// DEPTH from 2 up to FIFO_DEPTH so level_t holds the count; out_beat is don't-care while empty
`timescale 1ns/1ps
`include "stream_settings.svh"

module axis_srl_fifo
    import stream_pkg::*;
#(
    parameter int DEPTH = `FIFO_DEPTH
)
(
    input  logic   clk,
    input  logic   rst,
    input  beat_t  in_beat,     // write side
    input  logic   in_valid,
    output logic   in_ready,
    output beat_t  out_beat,    // read side
    output logic   out_valid,
    input  logic   out_ready,
    output level_t level        // entries held
);

    localparam int ADDR_W = $clog2(DEPTH);

    beat_t             mem [DEPTH];   // shift chain, newest at 0
    level_t            ptr;           // occupancy
    logic              full_reg;
    logic              empty_reg;
    logic              full_next;
    logic              empty_next;
    logic              shift;         // write, all entries move up one
    logic              inc;
    logic              dec;
    logic              ptr_empty;
    logic              ptr_empty1;
    logic              ptr_full1;
    logic [ADDR_W-1:0] rd_idx;

    // =====================================================================
    // read port and flags
    // =====================================================================

    assign rd_idx    = ADDR_W'(ptr - 1'b1);   // oldest entry at ptr-1
    assign out_beat  = mem[rd_idx];
    assign in_ready  = ~full_reg;
    assign out_valid = ~empty_reg;
    assign level     = ptr;

    assign ptr_empty  = (ptr == '0);
    assign ptr_empty1 = (ptr == level_t'(1));
    assign ptr_full1  = (ptr == level_t'(DEPTH - 1));

    // =====================================================================
    // next state, push while pop first
    // =====================================================================

    always_comb begin
        shift      = 1'b0;
        inc        = 1'b0;
        dec        = 1'b0;
        full_next  = full_reg;
        empty_next = empty_reg;
        if (out_ready && in_valid && !full_reg) begin
            shift      = 1'b1;
            inc        = ptr_empty;       // nothing to pop when empty
            empty_next = 1'b0;
        end else if (out_ready && out_valid) begin
            dec        = 1'b1;            // pop only
            full_next  = 1'b0;
            empty_next = ptr_empty1;
        end else if (in_valid && in_ready) begin
            shift      = 1'b1;            // push only
            inc        = 1'b1;
            full_next  = ptr_full1;
            empty_next = 1'b0;
        end
    end

    // =====================================================================
    // storage and pointer
    // =====================================================================

    always_ff @(posedge clk) begin
        if (shift) begin
            mem[0] <= in_beat;
            for (int i = 0; i < DEPTH-1; i++) begin
                mem[i+1] <= mem[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr       <= '0;
            full_reg  <= 1'b0;
            empty_reg <= 1'b1;
        end else begin
            if (inc) begin
                ptr <= ptr + 1'b1;
            end else if (dec) begin
                ptr <= ptr - 1'b1;
            end
            full_reg  <= full_next;
            empty_reg <= empty_next;
        end
    end

endmodule

//--- frame_sink.sv
// frame length wraps after 2**LEN_W words; checksum is a plain 16-bit add without carry fold
`timescale 1ns/1ps

module frame_sink
    import stream_pkg::*;
    import frame_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  beat_t         in_beat,      // beats from the FIFO
    input  logic          in_valid,
    output logic          in_ready,
    input  logic          hold,         // back-pressure request
    output frame_result_t result,       // totals of the last frame
    output logic          result_valid  // one-cycle strobe
);

    sink_state_t state;
    len_t        len_acc;     // words so far
    word_t       sum_acc;     // running sum mod 2**16
    logic        err_acc;     // OR of user bits

    logic        take;
    len_t        len_next;
    word_t       sum_next;
    logic        err_next;

    assign in_ready = ~hold;
    assign take     = in_valid && in_ready;

    // =====================================================================
    // totals including the word on the bus
    // =====================================================================

    always_comb begin
        if (state == sink_in_frame) begin
            len_next = len_acc + 1'b1;
            sum_next = sum_acc + in_beat.data;    // wraps mod 2**16
            err_next = err_acc | in_beat.user;
        end else begin
            len_next = len_t'(1);                 // first word opens the frame
            sum_next = in_beat.data;
            err_next = in_beat.user;
        end
    end

    // =====================================================================
    // control
    // =====================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= sink_idle;
            result_valid <= 1'b0;
        end else begin
            result_valid <= take && in_beat.last;     // one cycle after last edge
            if (take) begin
                state <= in_beat.last ? sink_idle : sink_in_frame;
            end
        end
    end

    // =====================================================================
    // accumulators and report
    // =====================================================================

    always_ff @(posedge clk) begin
        if (take) begin
            if (in_beat.last) begin
                result  <= '{len: len_next, sum: sum_next, error: err_next};
                len_acc <= '0;                        // ready for next frame
                sum_acc <= '0;
                err_acc <= 1'b0;
            end else begin
                len_acc <= len_next;
                sum_acc <= sum_next;
                err_acc <= err_next;
            end
        end
    end

endmodule

//--- stream_top.sv
// one clock domain, one stream; result latency depends on FIFO fill and sink_hold
`timescale 1ns/1ps
`include "stream_settings.svh"

module stream_top
    import stream_pkg::*;
    import frame_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  byte_t         in_byte,       // byte stream from the producer side
    input  logic          in_last,
    input  logic          in_error,
    input  logic          in_valid,
    output logic          in_ready,
    input  logic          sink_hold,     // stalls the sink while high
    output frame_result_t result,        // per-frame report
    output logic          result_valid,
    output level_t        level          // FIFO occupancy
);

    beat_t pk_beat;       // packer to FIFO
    logic  pk_valid;
    logic  pk_ready;
    beat_t fifo_beat;     // FIFO to sink
    logic  fifo_valid;
    logic  fifo_ready;

    byte_packer u_packer (
        .clk       (clk),
        .rst       (rst),
        .in_byte   (in_byte),
        .in_last   (in_last),
        .in_error  (in_error),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (pk_beat),
        .out_valid (pk_valid),
        .out_ready (pk_ready)
    );

    axis_srl_fifo #(
        .DEPTH (`FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (pk_beat),
        .in_valid  (pk_valid),
        .in_ready  (pk_ready),
        .out_beat  (fifo_beat),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .level     (level)
    );

    frame_sink u_sink (
        .clk          (clk),
        .rst          (rst),
        .in_beat      (fifo_beat),
        .in_valid     (fifo_valid),
        .in_ready     (fifo_ready),
        .hold         (sink_hold),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- tb_stream_top.sv
// stops at the first error; model assumes little-endian packing with zero padded short last words
`timescale 1ns/1ps
`include "stream_settings.svh"

module tb_stream_top
    import stream_pkg::*;
    import frame_pkg::*;
();

    localparam int BYTE_TIMEOUT  = 2000;     // cycles a byte may wait for in_ready
    localparam int STALL_TIMEOUT = 2000;
    localparam int DRAIN_TIMEOUT = 5000;
    localparam int HOLD_CAP      = 100000;   // toggler safety bound

    logic          clk;
    logic          rst;
    byte_t         in_byte;
    logic          in_last;
    logic          in_error;
    logic          in_valid;
    logic          in_ready;
    logic          sink_hold;
    frame_result_t result;
    logic          result_valid;
    level_t        level;

    logic [31:0]   seed;          // stimulus generator state
    logic [31:0]   hold_seed;     // separate stream for hold phases
    frame_result_t exp_q[$];      // expected reports in frame order
    word_t         m_word;        // model word under construction
    int            m_lane;
    len_t          m_len;
    word_t         m_sum;
    logic          m_err;
    int            sent_frames;
    int            got_count;
    int            err_frames;
    int            clean_frames;
    int            hold_cycles;   // consecutive negedges with hold on
    logic          frames_done;

    stream_top DUT (
        .clk          (clk),
        .rst          (rst),
        .in_byte      (in_byte),
        .in_last      (in_last),
        .in_error     (in_error),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .sink_hold    (sink_hold),
        .result       (result),
        .result_valid (result_valid),
        .level        (level)
    );

    always #50 clk = ~clk;        // 100 ns period

    // ========================================================================
    // random numbers and error exit
    // ========================================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        seed = lcg_next(seed);
        return (seed >> 8) % n;   // low bits of an LCG are weak
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_result(input frame_result_t exp, input frame_result_t act);
        if (act.len !== exp.len)
            stop_on_error($sformatf("Mismatch result.len expected 0x%h actual 0x%h",
                                    exp.len, act.len));
        if (act.sum !== exp.sum)
            stop_on_error($sformatf("Mismatch result.sum expected 0x%h actual 0x%h",
                                    exp.sum, act.sum));
        if (act.error !== exp.error)
            stop_on_error($sformatf("Mismatch result.error expected 0x%h actual 0x%h",
                                    exp.error, act.error));
    endtask

    task automatic check_level(input level_t exp, input level_t act);
        if (act !== exp)
            stop_on_error($sformatf("Mismatch level expected 0x%h actual 0x%h", exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("Mismatch %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    // ========================================================================
    // reference model fed with every accepted byte
    // ========================================================================

    task automatic model_byte(input byte_t b, input logic last, input logic err);
        frame_result_t exp_r;
        m_word = m_word | (word_t'(b) << (m_lane * `BYTE_W));  // lane 0 is the low byte
        m_err  = m_err | err;
        m_lane++;
        if (m_lane == `WORD_BYTES || last) begin
            m_sum  = m_sum + m_word;          // short word keeps zero pad lanes
            m_len  = m_len + 1'b1;
            m_word = '0;
            m_lane = 0;
        end
        if (last) begin
            exp_r.len   = m_len;
            exp_r.sum   = m_sum;
            exp_r.error = m_err;
            exp_q.push_back(exp_r);
            if (m_err) err_frames++;
            else clean_frames++;
            sent_frames++;
            m_len = '0;
            m_sum = '0;
            m_err = 1'b0;
        end
    endtask

    // ========================================================================
    // byte and frame drivers entered 1 ns after a rising edge
    // ========================================================================

    task automatic send_byte(input byte_t b, input logic last, input logic err);
        int waited;
        waited   = 0;
        in_byte  = b;
        in_last  = last;
        in_error = err;
        in_valid = 1'b1;
        @(negedge clk);
        while (in_ready !== 1'b1) begin          // ready is stable mid cycle
            waited++;
            if (waited > BYTE_TIMEOUT)
                stop_on_error("timeout waiting for in_ready to accept a byte");
            @(negedge clk);
        end
        model_byte(b, last, err);               // transfers on the coming edge
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_frames(input int count);
        int unsigned len;
        byte_t       b;
        logic        err;
        for (int f = 0; f < count; f++) begin
            len = rand_below(20) + 1;           // 1 to 20 bytes
            for (int i = 0; i < len; i++) begin
                b   = byte_t'(rand_below(256));
                err = (rand_below(16) == 0);    // about 1 in 16
                send_byte(b, (i == len - 1), err);
                if (rand_below(4) == 0) begin
                    repeat (rand_below(3) + 1) begin   // valid gap
                        @(posedge clk);
                        #1;
                    end
                end
            end
        end
    endtask

    // ========================================================================
    // monitor sampling at the falling edge
    // ========================================================================

    always @(negedge clk) begin
        if (!rst) begin
            if (level > `FIFO_DEPTH)
                stop_on_error($sformatf("FIFO level 0x%h went above the depth", level));
            hold_cycles = (sink_hold === 1'b1) ? hold_cycles + 1 : 0;
            if (result_valid === 1'b1) begin
                if (hold_cycles >= 2)
                    stop_on_error("result_valid pulsed while sink_hold was on");
                if (exp_q.size() == 0)
                    stop_on_error("result_valid pulsed with no frame pending");
                check_result(exp_q.pop_front(), result);
                got_count++;
            end
        end
    end

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin
        int waited;
        int cycles;
        int phase_left;
        clk = 1'b0;
        rst = 1'b1;
        in_byte = '0;
        in_last = 1'b0;
        in_error = 1'b0;
        in_valid = 1'b0;
        sink_hold = 1'b0;
        seed = 32'h411d924f;
        hold_seed = lcg_next(32'h411d924f ^ 32'h5a5a5a5a);
        m_word = '0;
        m_lane = 0;
        m_len = '0;
        m_sum = '0;
        m_err = 1'b0;
        sent_frames = 0;
        got_count = 0;
        err_frames = 0;
        clean_frames = 0;
        hold_cycles = 0;
        frames_done = 1'b0;

        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        @(negedge clk);                          // state right after reset
        check_flag("in_ready", 1'b1, in_ready);
        check_flag("result_valid", 1'b0, result_valid);
        check_level('0, level);
        @(posedge clk);
        #1;

        send_frames(200);                        // free flowing with hold low

        sink_hold = 1'b1;                        // long back-pressure stretch
        fork
            send_frames(30);
            begin
                waited = 0;
                @(negedge clk);
                while (in_ready !== 1'b0) begin
                    waited++;
                    if (waited > STALL_TIMEOUT)
                        stop_on_error("timeout waiting for in_ready to drop under hold");
                    @(negedge clk);
                end
                check_level(level_t'(`FIFO_DEPTH), level);   // stall means full
                repeat (30) @(posedge clk);
                #1 sink_hold = 1'b0;
            end
        join

        fork                                     // random hold phases
            begin
                send_frames(30);
                frames_done = 1'b1;
            end
            begin
                cycles = 0;
                phase_left = 0;
                while (!frames_done) begin
                    @(posedge clk);
                    #1;
                    if (phase_left == 0) begin
                        hold_seed  = lcg_next(hold_seed);
                        sink_hold  = hold_seed[31];
                        phase_left = hold_seed[30:27] + 1;
                    end
                    phase_left--;
                    cycles++;
                    if (cycles > HOLD_CAP)
                        stop_on_error("hold phases ran past their cycle limit");
                end
                sink_hold = 1'b0;
            end
        join

        waited = 0;                              // drain all pending frames
        while (got_count != sent_frames) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT)
                stop_on_error("timeout waiting for the remaining frame results");
        end
        @(negedge clk);
        check_level('0, level);
        repeat (50) @(posedge clk);              // monitor flags any extra pulse
        if (err_frames == 0 || clean_frames == 0)
            stop_on_error("stimulus lacked either error frames or clean frames");
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
stream_pkg.sv
frame_pkg.sv
byte_packer.sv
axis_srl_fifo.sv
frame_sink.sv
stream_top.sv
tb_stream_top.sv

//--- Bender.yml
package:
  name: stream_frames

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - stream_pkg.sv
      - frame_pkg.sv
      - byte_packer.sv
      - axis_srl_fifo.sv
      - frame_sink.sv
      - stream_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_stream_top.sv
